/* mem_stage.f */
hdl/lsu_isa_pkg.sv
hdl/dmem_bus_pkg.sv
hdl/memory_block.sv
hdl/dmemory.sv
hdl/lsu_decode.sv
hdl/load_align.sv
hdl/mem_stage.sv
tests/mem_stage_chk.sv
tests/mem_stage_tb.sv

/* Makefile */
# all of these can be set on the command line
VERILATOR   ?= verilator
TOP         ?= mem_stage_tb
FILELIST    ?= mem_stage.f
OBJ_DIR     ?= obj_dir
VFLAGS      ?= --binary --timing --assert -Wno-fatal
ERROR_LIMIT ?= 100
PASS_MSG    ?= TESTBENCH PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN) +verilator+error+limit+$(ERROR_LIMIT))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tests/mem_stage_tb.sv */
`timescale 1ns/1ps

module mem_stage_tb;
    import lsu_isa_pkg::*;

    localparam int ADDR_W     = 10;
    localparam int CLK_PERIOD = 4;
    localparam int NUM_REQS   = 87;             // requests issued over all tests
    localparam int MEM_BYTES  = 4 << ADDR_W;

    logic            clk;
    logic            arst_n;
    logic            req_valid;
    lsu_req_t        req;
    logic            load_valid;
    logic            misalign_err;
    logic [XLEN-1:0] load_data;
    logic [7:0]      ref_mem [MEM_BYTES];       // reference memory, byte addressed
    logic            exp_load;                  // expectation for the request in flight
    logic            exp_err;
    logic [XLEN-1:0] exp_data;
    int              errors;
    int              checks;
    integer          seed;

    mem_stage #(.ADDR_W(ADDR_W)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==============================
    // compare tasks and reference model
    // ==============================
    task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    // little endian word at addr, then extended by the load kind
    function automatic logic [XLEN-1:0] ref_load(input mem_op_e op, input logic [XLEN-1:0] addr);
        logic [XLEN-1:0] w;
        for (int i = 0; i < 4; i++) w[8*i +: 8] = ref_mem[(addr + i) % MEM_BYTES];
        case (op)
            op_lb:   return {{24{w[7]}}, w[7:0]};
            op_lbu:  return {24'h0, w[7:0]};
            op_lh:   return {{16{w[15]}}, w[15:0]};
            op_lhu:  return {16'h0, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic check_result();
        check_flag("load_valid", exp_load, load_valid);
        check_flag("misalign_err", exp_err, misalign_err);
        if (exp_load) check_word("load_data", exp_data, load_data);
    endtask

    // checks the previous request, then drives the next one
    task automatic issue(input mem_op_e op, input logic [XLEN-1:0] addr,
                         input logic [XLEN-1:0] wdata);
        int size;
        size = (op inside {op_lb, op_lbu, op_sb}) ? 1 : (op inside {op_lh, op_lhu, op_sh}) ? 2 : 4;
        @(posedge clk);
        #1;
        check_result();
        exp_err  = (addr % size) != 0;          // natural alignment
        exp_load = !exp_err && !(op inside {op_sb, op_sh, op_sw});
        exp_data = ref_load(op, addr);
        if (!exp_err && !exp_load) begin
            for (int i = 0; i < size; i++) ref_mem[(addr + i) % MEM_BYTES] = wdata[8*i +: 8];
        end
        req_valid = 1'b1;
        req       = '{op: op, addr: addr, wdata: wdata};
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            check_result();
            exp_load  = 1'b0;
            exp_err   = 1'b0;
            req_valid = 1'b0;
        end
    endtask

    // ==============================
    // directed tests
    // ==============================
    task automatic test_word();
        for (int i = 0; i < 6; i++) issue(op_sw, 32'h40 + 32'(52 * i), $random(seed));
        for (int i = 0; i < 6; i++) issue(op_lw, 32'h40 + 32'(52 * i), '0);
        idle(1);
    endtask

    task automatic test_bytes();
        logic [XLEN-1:0] a;
        for (int off = 0; off < 4; off++) begin
            a = 32'h200 + 32'(off);
            issue(op_sw, 32'h200, 32'h1234_5678);                 // known word
            issue(op_sb, a, off[0] ? 32'hdead_be3a : 32'hdead_bec5);  // junk above the byte
            issue(op_lw, 32'h200, '0);
            issue(op_lb, a, '0);
            issue(op_lbu, a, '0);
        end
        idle(1);
    endtask

    task automatic test_halves();
        for (int off = 0; off < 4; off += 2) begin
            for (int k = 0; k < 2; k++) begin
                issue(op_sw, 32'h300, 32'h1234_5678);
                issue(op_sh, 32'h300 + 32'(off), k ? 32'hbeef_7ec3 : 32'h0bad_8a51);
                issue(op_lh, 32'h300 + 32'(off), '0);
                issue(op_lhu, 32'h300 + 32'(off), '0);
                issue(op_lw, 32'h300, '0);
            end
        end
        idle(1);
    endtask

    task automatic test_misalign();
        issue(op_sw, 32'h400, 32'hcafe_f00d);
        issue(op_lh, 32'h401, '0);
        issue(op_sh, 32'h403, 32'h0000_ffff);
        issue(op_lw, 32'h402, '0);
        issue(op_sw, 32'h401, 32'h1111_1111);
        issue(op_lhu, 32'h405, '0);
        issue(op_lw, 32'h400, '0);              // word untouched in the DUT
        idle(1);
    endtask

    task automatic test_b2b();
        logic [XLEN-1:0] word;
        logic [XLEN-1:0] next;
        for (int i = 0; i < 4; i++) issue(op_sw, 32'h500 + 32'(4 * i), $random(seed));
        for (int i = 0; i < 12; i++) begin
            word = 32'h500 + 32'(4 * (i % 4));
            next = i[0] ? 32'h500 + 32'(4 * ((i + 1) % 4)) : word;  // even i reads back
            case (i % 3)
                0:       issue(op_sb, word + 32'(i % 4), $random(seed));
                1:       issue(op_sh, word + 32'(2 * (i % 2)), $random(seed));
                default: issue(op_sw, word, $random(seed));
            endcase
            case (i % 4)
                0:       issue(op_lw, next, '0);
                1:       issue(op_lbu, next + 1, '0);
                2:       issue(op_lh, next + 2, '0);
                default: issue(op_lb, next + 3, '0);
            endcase
        end
        idle(1);
    endtask

    initial begin
        errors = 0;
        checks = 0;
        seed = 29625;
        exp_load = 1'b0;
        exp_err = 1'b0;
        exp_data = '0;
        arst_n = 1'b0;
        req_valid = 1'b0;
        req = '0;
        repeat (4) @(posedge clk);
        #1 arst_n = 1'b1;
        test_word();
        test_bytes();
        test_halves();
        test_misalign();
        test_b2b();
        errors = errors + DUT.u_chk.fail_count;    // bound assertion failures
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog, four cycles per request plus reset and idle margin
    initial begin
        #((NUM_REQS * 4 + 40) * CLK_PERIOD);
        $display("Timeout: the directed tests did not finish in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* tests/mem_stage_chk.sv */
`timescale 1ns/1ps

module mem_stage_chk (
    input logic                     clk,
    input logic                     arst_n,
    input logic                     req_valid,
    input dmem_bus_pkg::dmem_port_t port,
    input logic                     load_valid,
    input logic                     misalign_err
);
    int fail_count = 0;                         // assertion failures so far

    // ==============================
    // memory controls, result pulses
    // ==============================
    a_ceb_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        !port.ceb |-> req_valid)
        else begin
            fail_count++;
            $error("memory selected without a request");
        end

    a_one_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        !(load_valid && misalign_err))
        else begin
            fail_count++;
            $error("load_valid and misalign_err high together");
        end

    // nothing comes out while held in reset
    a_quiet_reset: assert property (@(posedge clk)
        !arst_n |-> (!load_valid && !misalign_err))
        else begin
            fail_count++;
            $error("result pulse during reset");
        end

endmodule

bind mem_stage mem_stage_chk u_chk (
    .clk          (clk),
    .arst_n       (arst_n),
    .req_valid    (req_valid),
    .port         (dmem_port),
    .load_valid   (load_valid),
    .misalign_err (misalign_err)
);

/* hdl/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage #(
    parameter int ADDR_W = 10      // word address width, depth is 2**ADDR_W
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          req_valid,   // single cycle strobe
    input  lsu_isa_pkg::lsu_req_t         req,
    output logic                          load_valid,
    output logic [lsu_isa_pkg::XLEN-1:0]  load_data,
    output logic                          misalign_err
);
    import lsu_isa_pkg::*;
    import dmem_bus_pkg::*;

    dmem_port_t        dmem_port;  // decode to banks
    load_ctx_t         load_ctx;   // decode to result stage
    logic [DATA_W-1:0] dmem_q;     // bank read word

    // ==============================
    // decode, memory, result
    // ==============================
    lsu_decode #(
        .ADDR_W    (ADDR_W)
    ) u_decode (
        .req_valid (req_valid),
        .req       (req),
        .port      (dmem_port),
        .ctx       (load_ctx)
    );

    dmemory #(
        .ADDR_W    (ADDR_W)
    ) u_dmemory (
        .clk       (clk),
        .port      (dmem_port),
        .q         (dmem_q)
    );

    // context captured on the same edge as the memory command
    load_align u_load_align (
        .clk          (clk),
        .arst_n       (arst_n),
        .req_valid    (req_valid),
        .ctx          (load_ctx),
        .q            (dmem_q),
        .load_valid   (load_valid),
        .misalign_err (misalign_err),
        .load_data    (load_data)
    );

endmodule

/* hdl/load_align.sv */
`timescale 1ns/1ps

module load_align (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          req_valid,
    input  lsu_isa_pkg::load_ctx_t        ctx,
    input  logic [lsu_isa_pkg::XLEN-1:0]  q,          // raw word from the banks
    output logic                          load_valid,
    output logic                          misalign_err,
    output logic [lsu_isa_pkg::XLEN-1:0]  load_data
);
    import lsu_isa_pkg::*;

    load_ctx_t       ctx_r;        // context of the request in memory
    logic            valid_r;
    logic [XLEN-1:0] shifted;      // addressed bytes moved down to lane 0
    logic [7:0]      byte_sel;
    logic [15:0]     half_sel;

    // ==============================
    // context register
    // ==============================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctx_r   <= '0;
            valid_r <= 1'b0;
        end else begin
            ctx_r   <= ctx;
            valid_r <= req_valid;
        end
    end

    // result pulses, one cycle after the request
    assign misalign_err = valid_r & ctx_r.misaligned;
    assign load_valid   = valid_r & ctx_r.is_load & ~ctx_r.misaligned;

    // ==============================
    // extract and extend
    // ==============================
    assign shifted  = q >> {ctx_r.offset, 3'b000};
    assign byte_sel = shifted[7:0];
    assign half_sel = shifted[15:0];   // offset 0 or 2 for aligned halfwords

    always_comb begin
        case (ctx_r.op)
            op_lb:   load_data = {{(XLEN-8){byte_sel[7]}}, byte_sel};     // sign extend
            op_lbu:  load_data = {{(XLEN-8){1'b0}}, byte_sel};
            op_lh:   load_data = {{(XLEN-16){half_sel[15]}}, half_sel};
            op_lhu:  load_data = {{(XLEN-16){1'b0}}, half_sel};
            default: load_data = q;    // lw passes the word through
        endcase
    end

endmodule

/* hdl/lsu_decode.sv */
`timescale 1ns/1ps

module lsu_decode #(
    parameter int ADDR_W = 10
) (
    input  logic                     req_valid,
    input  lsu_isa_pkg::lsu_req_t    req,
    output dmem_bus_pkg::dmem_port_t port,
    output lsu_isa_pkg::load_ctx_t   ctx
);
    import lsu_isa_pkg::*;
    import dmem_bus_pkg::*;

    logic [1:0]           offset;       // byte lane of the access
    mem_size_e            size;
    logic                 is_load;
    logic                 is_store;
    logic                 misaligned;
    logic [DATA_W-1:0]    lane_data;    // store data moved into its lanes
    logic [NUM_LANES-1:0] lane_mask;

    assign offset = req.addr[1:0];

    // ==============================
    // op classification
    // ==============================
    always_comb begin
        size     = sz_word;
        is_load  = 1'b0;
        is_store = 1'b0;
        case (req.op)
            op_lb, op_lbu: begin
                size    = sz_byte;
                is_load = 1'b1;
            end
            op_lh, op_lhu: begin
                size    = sz_half;
                is_load = 1'b1;
            end
            op_lw:   is_load = 1'b1;
            op_sb: begin
                size     = sz_byte;
                is_store = 1'b1;
            end
            op_sh: begin
                size     = sz_half;
                is_store = 1'b1;
            end
            op_sw:   is_store = 1'b1;
            default: size = sz_word;     // unknown code, no access
        endcase
    end

    // halfword needs bit 0 clear, word needs both low bits clear
    always_comb begin
        case (size)
            sz_half: misaligned = offset[0];
            sz_word: misaligned = |offset;
            default: misaligned = 1'b0;
        endcase
        if (!(is_load || is_store)) begin
            misaligned = 1'b0;
        end
    end

    // ==============================
    // lane placement and byte mask
    // ==============================
    always_comb begin
        case (size)
            sz_byte: begin
                lane_data = DATA_W'(req.wdata[7:0]) << {offset, 3'b000};
                lane_mask = 4'b0001 << offset;
            end
            sz_half: begin
                lane_data = DATA_W'(req.wdata[15:0]) << {offset, 3'b000};
                lane_mask = 4'b0011 << offset;  // offset is 0 or 2 here
            end
            default: begin
                lane_data = req.wdata;
                lane_mask = 4'b1111;
            end
        endcase
    end

    always_comb begin
        port      = '0;
        port.ceb  = ~(req_valid & (is_load | is_store) & ~misaligned);
        port.web  = ~(req_valid & is_store & ~misaligned);   // low only for aligned store
        port.addr[ADDR_W-1:0] = req.addr[ADDR_W+1:2];
        port.mask = is_store ? lane_mask : '0;
        port.d    = lane_data;
    end

    assign ctx = '{op: req.op, offset: offset, is_load: is_load, misaligned: misaligned};

endmodule

/* hdl/dmemory.sv */
`timescale 1ns/1ps

module dmemory #(
    parameter int ADDR_W = 10
) (
    input  logic                            clk,
    input  dmem_bus_pkg::dmem_port_t        port,
    output logic [dmem_bus_pkg::DATA_W-1:0] q
);
    import dmem_bus_pkg::*;

    logic [LANE_W-1:0] wr_lane [NUM_LANES];   // d split per bank
    logic [LANE_W-1:0] rd_lane [NUM_LANES];   // bank outputs

    // ==============================
    // byte banks side by side
    // ==============================
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        assign wr_lane[i] = port.d[i*LANE_W +: LANE_W];
        assign q[i*LANE_W +: LANE_W] = rd_lane[i];   // lane 0 is the low byte

        memory_block #(
            .ADDR_W   (ADDR_W)
        ) u_bank (
            .clk      (clk),
            .ceb      (port.ceb),
            .web      (port.web),
            .write_en (port.mask[i]),     // one mask bit per bank
            .a        (port.addr[ADDR_W-1:0]),
            .d        (wr_lane[i]),
            .q        (rd_lane[i])
        );
    end

endmodule

/* hdl/memory_block.sv */
`timescale 1ns/1ps

module memory_block #(
    parameter int ADDR_W = 10
) (
    input  logic                            clk,
    input  logic                            ceb,       // chip enable, active low
    input  logic                            web,       // 0 write, 1 read
    input  logic                            write_en,  // lane select from the mask
    input  logic [ADDR_W-1:0]               a,
    input  logic [dmem_bus_pkg::LANE_W-1:0] d,
    output logic [dmem_bus_pkg::LANE_W-1:0] q
);
    import dmem_bus_pkg::*;

    // 2**ADDR_W bytes, contents undefined after power up
    logic [LANE_W-1:0] mem [0:(1 << ADDR_W)-1];

    // ==============================
    // single port, sync read
    // ==============================
    always_ff @(posedge clk) begin
        if (!ceb) begin
            if (!web) begin
                if (write_en) begin
                    mem[a] <= d;      // masked lanes only
                end
            end else begin
                q <= mem[a];          // read data next cycle
            end
        end
        // q keeps its value while deselected
    end

endmodule

/* hdl/dmem_bus_pkg.sv */
package dmem_bus_pkg;

    // ==============================
    // memory side view, byte banks
    // ==============================

    localparam int NUM_LANES  = 4;           // one bank per byte lane
    localparam int LANE_W     = 8;           // bank width
    localparam int DATA_W     = NUM_LANES * LANE_W;

    // widest word address the port can carry
    localparam int ADDR_MAX_W = 16;

    // command sampled by the banks on the clock edge
    typedef struct packed {
        logic                  ceb;          // chip enable, active low
        logic                  web;          // 0 write, 1 read
        logic [ADDR_MAX_W-1:0] addr;         // word address, low ADDR_W bits used
        logic [NUM_LANES-1:0]  mask;         // per lane write enable
        logic [DATA_W-1:0]     d;            // lane placed write data
    } dmem_port_t;

endpackage

/* hdl/lsu_isa_pkg.sv */
package lsu_isa_pkg;

    // ==============================
    // instruction side view of a memory access
    // ==============================

    localparam int XLEN = 32;                // register width

    // funct3 field of the RV32I load / store encodings
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    // bit 3 marks a store, low bits carry funct3
    typedef enum logic [3:0] {
        op_lb  = {1'b0, F3_B},
        op_lh  = {1'b0, F3_H},
        op_lw  = {1'b0, F3_W},
        op_lbu = {1'b0, F3_BU},
        op_lhu = {1'b0, F3_HU},
        op_sb  = {1'b1, F3_B},
        op_sh  = {1'b1, F3_H},
        op_sw  = {1'b1, F3_W}
    } mem_op_e;

    // access size class
    typedef enum logic [1:0] {
        sz_byte = 2'b00,
        sz_half = 2'b01,
        sz_word = 2'b10
    } mem_size_e;

    typedef struct packed {
        mem_op_e         op;
        logic [XLEN-1:0] addr;               // byte address
        logic [XLEN-1:0] wdata;              // store data, low bits used for sb / sh
    } lsu_req_t;

    // follows a request from decode to the result stage
    typedef struct packed {
        mem_op_e    op;
        logic [1:0] offset;                  // byte offset inside the word
        logic       is_load;
        logic       misaligned;
    } load_ctx_t;

endpackage
